// ==== bench/stbuf_tb.sv ====
`timescale 1ns/1ns

module stbuf_tb
  import stbuf_pkg::*;
();

  localparam int          CLK_PERIOD  = 10;
  localparam int          N_STORES    = 300;
  localparam int          WDOG_CYCLES = 400;   // Per store
  localparam int          DRAIN_IDLE  = 50;
  localparam int          FWD_WINDOW  = 4;
  localparam int          N_DELAYS    = 256;
  localparam int unsigned SEED        = 32'haca1_a8c8;

  logic        clk, reset_n;
  logic        st_valid, st_ready, fwd_valid, fwd_hit;
  st_req_t     st_req;
  paddr_t      fwd_paddr;
  logic        rsp_valid, mem_rd_valid;
  lrq_oh_t     rsp_index;
  line_t       rsp_data;
  mem_rd_req_t mem_rd;
  mem_wr_t     mem_wr;

  // Memory and reference model, keyed by line
  line_t      mem [line_addr_t];
  line_t      model [line_addr_t];
  bit         stored_line [line_addr_t];
  bit         fetch_busy [line_addr_t];
  // One buffer entry per doubleword at most
  int         pend_cnt [dw_addr_t];
  st_strb_t   pend_strb [dw_addr_t];
  paddr_t     pend_paddr [dw_addr_t];
  int         last_rep [dw_addr_t];
  line_addr_t fq_line [$];
  lrq_oh_t    fq_index [$];
  int         fq_due [$];
  int         delays [N_DELAYS];
  int         cycle, n_accepted, n_reports, n_fetches, n_issued;
  bit         st_taken;

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clk_gen_i (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  stbuf_subsys stbuf_subsys_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_st_valid     (st_valid),
    .i_st           (st_req),
    .i_fwd_valid    (fwd_valid),
    .i_fwd_paddr    (fwd_paddr),
    .i_mem_rd_valid (rsp_valid),
    .i_mem_rd_index (rsp_index),
    .i_mem_rd_data  (rsp_data),
    .o_st_ready     (st_ready),
    .o_fwd_hit      (fwd_hit),
    .o_mem_rd_valid (mem_rd_valid),
    .o_mem_rd       (mem_rd),
    .o_mem_wr       (mem_wr)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("Error at %0t ns: %s", $time, msg));
  endtask

  task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t want, input string what);
    if (got !== want) begin
      report_error($sformatf("%s got %h/%h/%h expected %h/%h/%h (paddr/strb/data)", what,
                             got.paddr, got.strb, got.data, want.paddr, want.strb, want.data));
    end
  endtask

  task automatic check_fwd(input logic got, input logic want, input string what);
    if (got !== want) report_error($sformatf("%s fwd_hit %b expected %b", what, got, want));
  endtask

  task automatic check_ready(input logic got, input logic want, input string what);
    if (got !== want) report_error($sformatf("%s st_ready %b expected %b", what, got, want));
  endtask

  task automatic check_line(input line_t got, input line_t want, input string what);
    if (got !== want) report_error($sformatf("%s got %h expected %h", what, got, want));
  endtask

  function automatic line_addr_t pool_line(input int k);
    line_addr_t la;
    la = '0;
    la[L1D_SET_W-1:0]         = L1D_SET_W'(1 + k / 2);   // Sets 1 to 3
    la[L1D_SET_W +: L1D_TAG_W] = (k % 2 == 1) ? 8'h34 : 8'h12;
    return la;
  endfunction

  function automatic paddr_t random_paddr();
    paddr_t pa;
    pa = '0;
    pa[PADDR_W-1:LINE_OFS_W] = pool_line($urandom_range(5));
    pa[LINE_OFS_W-1:0]       = LINE_OFS_W'($urandom_range(LINE_B - 1));
    return pa;
  endfunction

  function automatic st_data_t keep_strobed(input st_data_t d, input st_strb_t s);
    st_data_t r;
    r = '0;
    for (int b = 0; b < ST_DATA_B; b++) begin
      if (s[b]) r[b*8 +: 8] = d[b*8 +: 8];
    end
    return r;
  endfunction

  function automatic st_data_t read_dw(input line_t l, input paddr_t a);
    int base;
    base = a[LINE_OFS_W-1:DW_OFS_W] * ST_DATA_W;
    return l[base +: ST_DATA_W];
  endfunction

  function automatic line_t write_dw(input line_t l, input paddr_t a, input st_data_t d,
                                     input st_strb_t s);
    line_t r;
    int    base;
    r    = l;
    base = a[LINE_OFS_W-1:DW_OFS_W] * ST_DATA_W;
    for (int b = 0; b < ST_DATA_B; b++) begin
      if (s[b]) r[base + b*8 +: 8] = d[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic drive_probe();
    fwd_valid = ($urandom_range(2) == 0);
    fwd_paddr = random_paddr();
  endtask

  task automatic drive_store();
    paddr_t pa;
    if (n_issued > 0 && $urandom_range(1) == 1) begin
      pa = st_req.paddr;   // Burst on the same doubleword
      pa[DW_OFS_W-1:0] = DW_OFS_W'($urandom_range(ST_DATA_B - 1));
    end else begin
      pa = random_paddr();
    end
    st_valid     = 1'b1;
    st_req.paddr = pa;
    st_req.data  = {$urandom, $urandom};
    st_req.strb  = ST_DATA_B'($urandom_range(255, 1));
    n_issued++;
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    int unsigned seed_ret;
    line_addr_t  la;
    seed_ret  = $urandom(SEED);
    st_valid  = 1'b0;
    st_req    = '0;
    fwd_valid = 1'b0;
    fwd_paddr = '0;
    rsp_valid = 1'b0;
    rsp_index = '0;
    rsp_data  = '0;
    for (int k = 0; k < 6; k++) begin
      la        = pool_line(k);
      mem[la]   = {$urandom, $urandom, $urandom, $urandom};
      model[la] = mem[la];
    end
    for (int d = 0; d < N_DELAYS; d++) delays[d] = 3 + $urandom_range(9);
    @(posedge reset_n);
    while (n_accepted < N_STORES) begin
      @(posedge clk);
      #1;
      drive_probe();
      if (st_taken || !st_valid) begin
        if (n_issued < N_STORES && $urandom_range(3) != 0) begin
          drive_store();
        end else begin
          st_valid = 1'b0;
        end
      end
    end
    while (pend_cnt.num() != 0) begin
      @(posedge clk);
      #1;
      drive_probe();
    end
    repeat (DRAIN_IDLE) begin
      @(posedge clk);
      #1;
      drive_probe();
    end
    fwd_valid = 1'b0;
    for (int k = 0; k < 6; k++) begin
      check_line(mem[pool_line(k)], model[pool_line(k)], "final memory line");
    end
    if (n_reports >= n_accepted) begin
      abort_run("Stores to the same doubleword were never merged into one write");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Memory responder, any order
  // ------------------------------------------------------------
  initial begin : mem_responder
    int k;
    @(posedge reset_n);
    forever begin
      @(posedge clk);
      #1;
      rsp_valid = 1'b0;
      for (k = 0; k < fq_due.size(); k++) begin
        if (fq_due[k] <= cycle) break;
      end
      if (k < fq_due.size()) begin
        rsp_valid = 1'b1;
        rsp_index = fq_index[k];
        rsp_data  = mem[fq_line[k]];
        fetch_busy.delete(fq_line[k]);
        fq_line.delete(k);
        fq_index.delete(k);
        fq_due.delete(k);
      end
    end
  end

  // ------------------------------------------------------------
  // Monitor at the falling edge
  // ------------------------------------------------------------
  initial begin : monitor
    dw_addr_t   dw;
    line_addr_t la;
    mem_wr_t    got;
    mem_wr_t    want;
    forever begin
      @(negedge clk);
      if (reset_n) begin
        cycle++;
        if (fwd_valid) begin
          dw = fwd_paddr[PADDR_W-1:DW_OFS_W];
          if (pend_cnt.exists(dw)) begin
            check_fwd(fwd_hit, 1'b1, "probe of a buffered doubleword");
          end else if (!last_rep.exists(dw) || cycle - last_rep[dw] > FWD_WINDOW) begin
            check_fwd(fwd_hit, 1'b0, "probe of an idle doubleword");
          end
        end
        // A reporting entry still holds its slot this cycle
        dw = st_req.paddr[PADDR_W-1:DW_OFS_W];
        if (st_valid && !pend_cnt.exists(dw) && pend_cnt.num() < ST_BUF_ENTRIES) begin
          check_ready(st_ready, 1'b1, "store with a free entry");
        end
        if (mem_wr.valid) begin
          dw = mem_wr.paddr[PADDR_W-1:DW_OFS_W];
          la = mem_wr.paddr[PADDR_W-1:LINE_OFS_W];
          if (!pend_cnt.exists(dw)) begin
            abort_run("Memory write reported for a doubleword with no outstanding store");
          end
          got       = mem_wr;
          got.data  = keep_strobed(mem_wr.data, mem_wr.strb);
          want.valid = 1'b1;
          want.paddr = pend_paddr[dw];
          want.strb  = pend_strb[dw];
          want.data  = keep_strobed(read_dw(model[la], pend_paddr[dw]), pend_strb[dw]);
          check_mem_wr(got, want, "memory write report");
          mem[la] = write_dw(mem[la], mem_wr.paddr, mem_wr.data, mem_wr.strb);
          pend_cnt.delete(dw);   // Merged stores retire together
          pend_strb.delete(dw);
          pend_paddr.delete(dw);
          last_rep[dw] = cycle;
          n_reports++;
        end
        st_taken = st_valid && st_ready;
        if (st_taken) begin
          dw = st_req.paddr[PADDR_W-1:DW_OFS_W];
          la = st_req.paddr[PADDR_W-1:LINE_OFS_W];
          model[la] = write_dw(model[la], st_req.paddr, st_req.data, st_req.strb);
          if (pend_cnt.exists(dw)) begin
            pend_cnt[dw]  = pend_cnt[dw] + 1;
            pend_strb[dw] = pend_strb[dw] | st_req.strb;
          end else begin
            pend_cnt[dw]   = 1;
            pend_strb[dw]  = st_req.strb;
            pend_paddr[dw] = st_req.paddr;
          end
          stored_line[la] = 1'b1;
          n_accepted++;
        end
        if (mem_rd_valid) begin
          la = mem_rd.line_addr;
          if (!stored_line.exists(la)) abort_run("Line fetch for an address no store targeted");
          if (fetch_busy.exists(la)) abort_run("Second fetch issued for a line already pending");
          if ($countones(mem_rd.index_oh) != 1) begin
            abort_run("Line fetch carries a refill index that is not one-hot");
          end
          foreach (fq_index[q]) begin
            if (fq_index[q] == mem_rd.index_oh) begin
              abort_run("Line fetch reuses a refill index that is still in flight");
            end
          end
          fetch_busy[la] = 1'b1;
          fq_line.push_back(la);
          fq_index.push_back(mem_rd.index_oh);
          fq_due.push_back(cycle + delays[n_fetches % N_DELAYS]);
          n_fetches++;
        end
      end
    end
  end

  initial begin : watchdog
    #(N_STORES * WDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                        N_STORES * WDOG_CYCLES));
  end

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int CLK_PERIOD   = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset_n = 1'b1;   // Release just after an edge
  end

endmodule

// ==== common/stbuf_pkg.sv ====
package stbuf_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int PADDR_W        = 16;
  localparam int ST_BUF_ENTRIES = 4;
  localparam int ST_DATA_W      = 64;
  localparam int ST_DATA_B      = ST_DATA_W / 8;
  localparam int LINE_W         = 128;
  localparam int LINE_B         = LINE_W / 8;
  localparam int L1D_SETS       = 16;
  localparam int LRQ_ENTRIES    = 2;

  localparam int DW_OFS_W   = $clog2(ST_DATA_B);   // Byte offset in a doubleword
  localparam int LINE_OFS_W = $clog2(LINE_B);      // Byte offset in a line
  localparam int L1D_SET_W  = $clog2(L1D_SETS);
  localparam int L1D_TAG_W  = PADDR_W - LINE_OFS_W - L1D_SET_W;

  typedef logic [PADDR_W-1:0]            paddr_t;
  typedef logic [PADDR_W-DW_OFS_W-1:0]   dw_addr_t;
  typedef logic [PADDR_W-LINE_OFS_W-1:0] line_addr_t;
  typedef logic [ST_DATA_W-1:0]          st_data_t;
  typedef logic [ST_DATA_B-1:0]          st_strb_t;
  typedef logic [LINE_W-1:0]             line_t;
  typedef logic [LRQ_ENTRIES-1:0]        lrq_oh_t;

  typedef struct packed {
    paddr_t   paddr;
    st_data_t data;
    st_strb_t strb;
  } st_req_t;

  typedef struct packed {
    logic     valid;
    paddr_t   paddr;
    st_data_t data;
    st_strb_t strb;
    lrq_oh_t  lrq_index_oh;   // Refill slot this entry waits on
  } st_buffer_entry_t;

  typedef struct packed {
    paddr_t paddr;
  } l1d_rd_req_t;

  typedef struct packed {
    logic hit;
    logic conflict;
  } l1d_s1_resp_t;

  typedef struct packed {
    paddr_t   paddr;
    st_data_t data;
    st_strb_t strb;
  } l1d_wr_req_t;

  typedef struct packed {
    lrq_oh_t index_oh;   // Nonzero when the line is already pending
    logic    full;
  } lrq_resp_t;

  typedef struct packed {
    logic    valid;
    lrq_oh_t resolve_index_oh;
    lrq_oh_t lrq_entry_valids;
  } lrq_resolve_t;

  typedef struct packed {
    line_addr_t line_addr;
    lrq_oh_t    index_oh;
  } mem_rd_req_t;

  typedef struct packed {
    logic     valid;
    paddr_t   paddr;
    st_data_t data;
    st_strb_t strb;
  } mem_wr_t;

  typedef enum logic [3:0] {
    ST_BUF_INIT,
    ST_BUF_RD_L1D,
    ST_BUF_RESP_L1D,
    ST_BUF_LRQ_REFILL,
    ST_BUF_WAIT_REFILL,
    ST_BUF_WAIT_FULL,
    ST_BUF_L1D_UPDATE,
    ST_BUF_L1D_UPD_RESP,
    ST_BUF_WAIT_FINISH
  } st_buffer_state_t;

endpackage

// ==== hdl/l1d_array.sv ====
`timescale 1ns/1ns

module l1d_array
  import stbuf_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic         i_rd_valid,
  input  l1d_rd_req_t  i_rd,
  input  logic         i_wr_valid,
  input  l1d_wr_req_t  i_wr,
  input  logic         i_refill_valid,
  input  line_addr_t   i_refill_addr,
  input  line_t        i_refill_data,
  output l1d_s1_resp_t o_s1_resp,
  output logic         o_wr_s1_resp_hit,
  output logic         o_busy
);

  logic [L1D_SETS-1:0]                r_valid;
  logic [L1D_TAG_W-1:0]               r_tag [L1D_SETS];
  line_t                              r_data [L1D_SETS];
  logic                               r_s1_valid;
  logic                               r_s1_conflict;
  logic [L1D_SET_W-1:0]               r_s1_set, w_rd_set, w_wr_set, w_refill_set;
  logic [L1D_TAG_W-1:0]               r_s1_tag, w_rd_tag, w_wr_tag, w_refill_tag;
  logic [LINE_OFS_W-DW_OFS_W-1:0]     w_wr_dw_sel;   // Doubleword slot in the line
  logic                               w_wr_hit;
  line_t                              w_wr_line;

  assign w_rd_set     = i_rd.paddr[LINE_OFS_W +: L1D_SET_W];
  assign w_rd_tag     = i_rd.paddr[PADDR_W-1 -: L1D_TAG_W];
  assign w_wr_set     = i_wr.paddr[LINE_OFS_W +: L1D_SET_W];
  assign w_wr_tag     = i_wr.paddr[PADDR_W-1 -: L1D_TAG_W];
  assign w_wr_dw_sel  = i_wr.paddr[DW_OFS_W +: (LINE_OFS_W - DW_OFS_W)];
  assign w_refill_set = i_refill_addr[L1D_SET_W-1:0];
  assign w_refill_tag = i_refill_addr[L1D_SET_W +: L1D_TAG_W];
  assign w_wr_hit     = i_wr_valid & r_valid[w_wr_set] & (r_tag[w_wr_set] == w_wr_tag);

  always_comb begin
    w_wr_line = r_data[w_wr_set];
    for (int b = 0; b < ST_DATA_B; b++) begin
      if (i_wr.strb[b]) begin
        w_wr_line[(w_wr_dw_sel*ST_DATA_B + b)*8 +: 8] = i_wr.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid          <= '0;
      r_s1_valid       <= 1'b0;
      r_s1_conflict    <= 1'b0;
      r_s1_set         <= '0;
      r_s1_tag         <= '0;
      o_wr_s1_resp_hit <= 1'b0;
      for (int s = 0; s < L1D_SETS; s++) begin
        r_tag[s]  <= '0;
        r_data[s] <= '0;
      end
    end else begin
      r_s1_valid       <= i_rd_valid;
      r_s1_conflict    <= i_rd_valid & i_refill_valid & (w_refill_set == w_rd_set);
      r_s1_set         <= w_rd_set;
      r_s1_tag         <= w_rd_tag;
      o_wr_s1_resp_hit <= w_wr_hit;
      if (w_wr_hit) r_data[w_wr_set] <= w_wr_line;
      if (i_refill_valid) begin   // Refill last, so it wins the set
        r_valid[w_refill_set] <= 1'b1;
        r_tag[w_refill_set]   <= w_refill_tag;
        r_data[w_refill_set]  <= i_refill_data;
      end
    end
  end

  // Tag compare in s1
  assign o_s1_resp.hit      = r_s1_valid & r_valid[r_s1_set] & (r_tag[r_s1_set] == r_s1_tag);
  assign o_s1_resp.conflict = r_s1_valid & r_s1_conflict;
  assign o_busy             = i_refill_valid;

endmodule

// ==== hdl/refill_queue.sv ====
`timescale 1ns/1ns

module refill_queue
  import stbuf_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  paddr_t       i_search_paddr,
  input  logic         i_req_valid,
  input  paddr_t       i_req_paddr,
  input  logic         i_mem_rd_valid,
  input  lrq_oh_t      i_mem_rd_index,
  input  line_t        i_mem_rd_data,
  output lrq_oh_t      o_search_hit,
  output lrq_resp_t    o_resp,
  output lrq_resolve_t o_resolve,
  output logic         o_mem_rd_valid,
  output mem_rd_req_t  o_mem_rd,
  output logic         o_refill_valid,
  output line_addr_t   o_refill_addr,
  output line_t        o_refill_data
);

  lrq_oh_t     r_valid;
  line_addr_t  r_addr [LRQ_ENTRIES];
  line_addr_t  w_search_line;
  line_addr_t  w_req_line;
  lrq_oh_t     w_req_hit;
  lrq_oh_t     w_alloc_oh;
  logic        w_full;
  logic        w_alloc;
  logic        r_mem_rd_valid;
  mem_rd_req_t r_mem_rd;
  logic        r_resolve_valid;
  lrq_oh_t     r_resolve_oh;

  assign w_search_line = i_search_paddr[PADDR_W-1:LINE_OFS_W];
  assign w_req_line    = i_req_paddr[PADDR_W-1:LINE_OFS_W];
  assign w_full        = &r_valid;
  assign w_alloc_oh    = ~r_valid & (r_valid + lrq_oh_t'(1));   // Lowest free slot
  assign w_alloc       = i_req_valid & ~|w_req_hit & !w_full;

  always_comb begin
    o_refill_addr = '0;
    for (int i = 0; i < LRQ_ENTRIES; i++) begin
      o_search_hit[i] = r_valid[i] & (r_addr[i] == w_search_line);
      w_req_hit[i]    = r_valid[i] & (r_addr[i] == w_req_line);
      if (i_mem_rd_index[i]) o_refill_addr = r_addr[i];
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid         <= '0;
      r_mem_rd_valid  <= 1'b0;
      r_mem_rd        <= '0;
      r_resolve_valid <= 1'b0;
      r_resolve_oh    <= '0;
    end else begin
      // Allocation never lands on the slot being freed
      r_valid <= (r_valid | (w_alloc ? w_alloc_oh : '0)) &
                 ~(i_mem_rd_valid ? i_mem_rd_index : '0);
      r_mem_rd_valid  <= w_alloc;
      r_mem_rd        <= '{line_addr: w_req_line, index_oh: w_alloc_oh};
      r_resolve_valid <= i_mem_rd_valid;
      r_resolve_oh    <= i_mem_rd_valid ? i_mem_rd_index : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < LRQ_ENTRIES; i++) begin
      if (w_alloc && w_alloc_oh[i]) r_addr[i] <= w_req_line;
    end
  end

  assign o_resp.index_oh            = w_req_hit;
  assign o_resp.full                = w_full;
  assign o_resolve.valid            = r_resolve_valid;
  assign o_resolve.resolve_index_oh = r_resolve_oh;
  assign o_resolve.lrq_entry_valids = r_valid;
  assign o_mem_rd_valid             = r_mem_rd_valid;
  assign o_mem_rd                   = r_mem_rd;
  assign o_refill_valid             = i_mem_rd_valid;   // Line goes straight to L1D
  assign o_refill_data              = i_mem_rd_data;

endmodule

// ==== hdl/stbuf_subsys.sv ====
`timescale 1ns/1ns

module stbuf_subsys
  import stbuf_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_st_valid,
  input  st_req_t     i_st,
  input  logic        i_fwd_valid,
  input  paddr_t      i_fwd_paddr,
  input  logic        i_mem_rd_valid,
  input  lrq_oh_t     i_mem_rd_index,
  input  line_t       i_mem_rd_data,
  output logic        o_st_ready,
  output logic        o_fwd_hit,
  output logic        o_mem_rd_valid,
  output mem_rd_req_t o_mem_rd,
  output mem_wr_t     o_mem_wr
);

  // ------------------------------------------------------------
  // Internal buses
  // ------------------------------------------------------------
  l1d_s1_resp_t w_l1d_s1_resp;
  logic         w_l1d_wr_s1_resp_hit, w_l1d_busy;
  logic         w_l1d_rd_valid, w_l1d_wr_valid;
  l1d_rd_req_t  w_l1d_rd;
  l1d_wr_req_t  w_l1d_wr;
  lrq_oh_t      w_lrq_search_hit;
  lrq_resp_t    w_lrq_resp;
  lrq_resolve_t w_lrq_resolve;
  logic         w_lrq_req_valid, w_refill_valid;
  paddr_t       w_lrq_paddr, w_search_paddr;
  line_addr_t   w_refill_addr;
  line_t        w_refill_data;

  st_buffer u_st_buffer (
    .i_clk, .i_reset_n, .i_st_valid, .i_st, .i_fwd_valid, .i_fwd_paddr,
    .i_l1d_s1_resp        (w_l1d_s1_resp),
    .i_l1d_wr_s1_resp_hit (w_l1d_wr_s1_resp_hit),
    .i_l1d_busy           (w_l1d_busy),
    .i_lrq_search_hit     (w_lrq_search_hit),
    .i_lrq_resp           (w_lrq_resp),
    .i_lrq_resolve        (w_lrq_resolve),
    .o_st_ready, .o_fwd_hit,
    .o_l1d_rd_valid       (w_l1d_rd_valid),
    .o_l1d_rd             (w_l1d_rd),
    .o_l1d_wr_valid       (w_l1d_wr_valid),
    .o_l1d_wr             (w_l1d_wr),
    .o_lrq_req_valid      (w_lrq_req_valid),
    .o_lrq_paddr          (w_lrq_paddr),
    .o_search_paddr       (w_search_paddr),
    .o_mem_wr
  );

  l1d_array u_l1d_array (
    .i_clk, .i_reset_n,
    .i_rd_valid       (w_l1d_rd_valid),
    .i_rd             (w_l1d_rd),
    .i_wr_valid       (w_l1d_wr_valid),
    .i_wr             (w_l1d_wr),
    .i_refill_valid   (w_refill_valid),
    .i_refill_addr    (w_refill_addr),
    .i_refill_data    (w_refill_data),
    .o_s1_resp        (w_l1d_s1_resp),
    .o_wr_s1_resp_hit (w_l1d_wr_s1_resp_hit),
    .o_busy           (w_l1d_busy)
  );

  refill_queue u_refill_queue (
    .i_clk, .i_reset_n,
    .i_search_paddr (w_search_paddr),
    .i_req_valid    (w_lrq_req_valid),
    .i_req_paddr    (w_lrq_paddr),
    .i_mem_rd_valid, .i_mem_rd_index, .i_mem_rd_data,
    .o_search_hit   (w_lrq_search_hit),
    .o_resp         (w_lrq_resp),
    .o_resolve      (w_lrq_resolve),
    .o_mem_rd_valid, .o_mem_rd,
    .o_refill_valid (w_refill_valid),
    .o_refill_addr  (w_refill_addr),
    .o_refill_data  (w_refill_data)
  );

endmodule

// ==== st_buffer/st_buffer.sv ====
`timescale 1ns/1ns

module st_buffer
  import stbuf_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic         i_st_valid,
  input  st_req_t      i_st,
  input  logic         i_fwd_valid,
  input  paddr_t       i_fwd_paddr,
  input  l1d_s1_resp_t i_l1d_s1_resp,
  input  logic         i_l1d_wr_s1_resp_hit,
  input  logic         i_l1d_busy,
  input  lrq_oh_t      i_lrq_search_hit,
  input  lrq_resp_t    i_lrq_resp,
  input  lrq_resolve_t i_lrq_resolve,
  output logic         o_st_ready,
  output logic         o_fwd_hit,
  output logic         o_l1d_rd_valid,
  output l1d_rd_req_t  o_l1d_rd,
  output logic         o_l1d_wr_valid,
  output l1d_wr_req_t  o_l1d_wr,
  output logic         o_lrq_req_valid,
  output paddr_t       o_lrq_paddr,
  output paddr_t       o_search_paddr,
  output mem_wr_t      o_mem_wr
);

  typedef logic [ST_BUF_ENTRIES-1:0] ent_mask_t;

  st_buffer_entry_t w_entries [ST_BUF_ENTRIES];
  st_buffer_entry_t w_new_entry;
  ent_mask_t        w_same_dw, w_mergeable, w_free, w_merge_oh, w_load_oh;
  ent_mask_t        w_rd_req, w_wr_req, w_lrq_req, w_finish_req, w_fwd_hit;
  ent_mask_t        w_rd_grant, w_wr_grant, w_lrq_grant, w_finish_grant;
  ent_mask_t        r_rd_oh;   // Entry now in RESP_L1D
  ent_mask_t        r_wr_oh;   // Entry now in L1D_UPD_RESP
  logic             w_stall;
  logic             w_st_fire;
  dw_addr_t         w_st_dw;
  mem_wr_t          w_mem_wr_next;
  mem_wr_t          r_mem_wr;

  // ------------------------------------------------------------
  // Store steering
  // ------------------------------------------------------------
  assign w_st_dw     = i_st.paddr[PADDR_W-1:DW_OFS_W];
  assign w_merge_oh  = w_same_dw & w_mergeable;
  assign w_stall     = |(w_same_dw & ~w_mergeable);   // Keep one doubleword in order
  assign w_load_oh   = w_free & (~w_free + ent_mask_t'(1));
  assign o_st_ready  = !w_stall & (|w_merge_oh | |w_free);
  assign w_st_fire   = i_st_valid & o_st_ready;
  assign w_new_entry = '{valid: 1'b1, paddr: i_st.paddr, data: i_st.data,
                         strb: i_st.strb, lrq_index_oh: '0};

  // Fixed priority, lowest index first
  assign w_rd_grant     = i_l1d_busy ? '0 : (w_rd_req & (~w_rd_req + ent_mask_t'(1)));
  assign w_wr_grant     = i_l1d_busy ? '0 : (w_wr_req & (~w_wr_req + ent_mask_t'(1)));
  assign w_lrq_grant    = w_lrq_req & (~w_lrq_req + ent_mask_t'(1));
  assign w_finish_grant = w_finish_req & (~w_finish_req + ent_mask_t'(1));

  for (genvar i = 0; i < ST_BUF_ENTRIES; i++) begin : g_entry
    assign w_free[i]    = !w_entries[i].valid;
    assign w_same_dw[i] = w_entries[i].valid &
                          (w_entries[i].paddr[PADDR_W-1:DW_OFS_W] == w_st_dw);

    st_buffer_entry u_entry (
      .i_clk, .i_reset_n,
      .i_load               (w_st_fire & ~|w_merge_oh & w_load_oh[i]),
      .i_merge_accept       (w_st_fire & w_merge_oh[i]),
      .i_entry              (w_new_entry),
      .i_l1d_rd_accepted    (w_rd_grant[i]),
      .i_l1d_s1_resp,
      .i_l1d_wr_accepted    (w_wr_grant[i]),
      .i_l1d_wr_s1_resp_hit,
      .i_lrq_accepted       (w_lrq_grant[i]),
      .i_lrq_search_hit,
      .i_lrq_resp,
      .i_lrq_resolve,
      .i_fwd_valid,
      .i_fwd_paddr,
      .i_finish_accepted    (w_finish_grant[i]),
      .o_l1d_rd_req         (w_rd_req[i]),
      .o_l1d_wr_req         (w_wr_req[i]),
      .o_lrq_req            (w_lrq_req[i]),
      .o_ready_to_merge     (w_mergeable[i]),
      .o_entry              (w_entries[i]),
      .o_fwd_hit            (w_fwd_hit[i]),
      .o_entry_finish       (w_finish_req[i])
    );
  end

  // ------------------------------------------------------------
  // Payload muxes
  // ------------------------------------------------------------
  always_comb begin
    o_l1d_rd       = '0;
    o_l1d_wr       = '0;
    o_lrq_paddr    = '0;
    o_search_paddr = '0;
    w_mem_wr_next  = '0;
    for (int i = 0; i < ST_BUF_ENTRIES; i++) begin
      if (w_rd_grant[i]) o_l1d_rd.paddr = w_entries[i].paddr;
      if (w_wr_grant[i]) begin
        o_l1d_wr = '{paddr: w_entries[i].paddr, data: w_entries[i].data,
                     strb: w_entries[i].strb};
      end
      if (w_lrq_grant[i]) o_lrq_paddr = w_entries[i].paddr;
      if (r_rd_oh[i]) o_search_paddr = w_entries[i].paddr;
      if (r_wr_oh[i]) begin
        w_mem_wr_next.paddr = w_entries[i].paddr;
        w_mem_wr_next.data  = w_entries[i].data;
        w_mem_wr_next.strb  = w_entries[i].strb;
      end
    end
    w_mem_wr_next.valid = |r_wr_oh & i_l1d_wr_s1_resp_hit;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_oh  <= '0;
      r_wr_oh  <= '0;
      r_mem_wr <= '0;
    end else begin
      r_rd_oh  <= w_rd_grant;
      r_wr_oh  <= w_wr_grant;
      r_mem_wr <= w_mem_wr_next;   // One report per finished entry
    end
  end

  assign o_l1d_rd_valid  = |w_rd_grant;
  assign o_l1d_wr_valid  = |w_wr_grant;
  assign o_lrq_req_valid = |w_lrq_grant;
  assign o_fwd_hit       = |w_fwd_hit;
  assign o_mem_wr        = r_mem_wr;

endmodule

// ==== st_buffer/st_buffer_entry.sv ====
`timescale 1ns/1ns

module st_buffer_entry
  import stbuf_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_load,
  input  logic             i_merge_accept,
  input  st_buffer_entry_t i_entry,
  input  logic             i_l1d_rd_accepted,
  input  l1d_s1_resp_t     i_l1d_s1_resp,
  input  logic             i_l1d_wr_accepted,
  input  logic             i_l1d_wr_s1_resp_hit,
  input  logic             i_lrq_accepted,
  input  lrq_oh_t          i_lrq_search_hit,
  input  lrq_resp_t        i_lrq_resp,
  input  lrq_resolve_t     i_lrq_resolve,
  input  logic             i_fwd_valid,
  input  paddr_t           i_fwd_paddr,
  input  logic             i_finish_accepted,
  output logic             o_l1d_rd_req,
  output logic             o_l1d_wr_req,
  output logic             o_lrq_req,
  output logic             o_ready_to_merge,
  output st_buffer_entry_t o_entry,
  output logic             o_fwd_hit,
  output logic             o_entry_finish
);

  st_buffer_entry_t r_entry;
  st_buffer_entry_t w_entry_next;
  st_buffer_state_t r_state;
  st_buffer_state_t w_state_next;
  logic             w_resolve_match;
  logic             w_dep_alive;
  dw_addr_t         w_entry_dw;
  dw_addr_t         w_fwd_dw;

  assign w_resolve_match = i_lrq_resolve.valid &
                           (i_lrq_resolve.resolve_index_oh == r_entry.lrq_index_oh);
  assign w_dep_alive = |(i_lrq_resolve.lrq_entry_valids & r_entry.lrq_index_oh);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry <= '0;
      r_state <= ST_BUF_INIT;
    end else begin
      r_entry <= w_entry_next;
      r_state <= w_state_next;
    end
  end

  always_comb begin
    w_entry_next = r_entry;
    w_state_next = r_state;

    // Later store wins on every strobed byte
    if (r_entry.valid && i_merge_accept) begin
      for (int b = 0; b < ST_DATA_B; b++) begin
        if (i_entry.strb[b]) begin
          w_entry_next.data[b*8 +: 8] = i_entry.data[b*8 +: 8];
        end
      end
      w_entry_next.strb = r_entry.strb | i_entry.strb;
    end

    case (r_state)
      ST_BUF_INIT: begin
        if (i_load) begin
          w_entry_next = i_entry;
          w_state_next = ST_BUF_RD_L1D;
        end
      end
      ST_BUF_RD_L1D: begin
        if (i_l1d_rd_accepted) w_state_next = ST_BUF_RESP_L1D;
      end
      ST_BUF_RESP_L1D: begin
        if (|i_lrq_search_hit) begin
          if (i_lrq_resolve.valid &&
              (i_lrq_resolve.resolve_index_oh == i_lrq_search_hit)) begin
            w_state_next = ST_BUF_RD_L1D;   // Line just landed, replay
          end else begin
            w_state_next = ST_BUF_WAIT_REFILL;
            w_entry_next.lrq_index_oh = i_lrq_search_hit;
          end
        end else if (i_l1d_s1_resp.conflict) begin
          w_state_next = ST_BUF_RD_L1D;
        end else if (!i_l1d_s1_resp.hit) begin
          w_state_next = ST_BUF_LRQ_REFILL;
        end else begin
          w_state_next = ST_BUF_L1D_UPDATE;
        end
      end
      ST_BUF_LRQ_REFILL: begin
        if (i_lrq_accepted) begin
          if (|i_lrq_resp.index_oh) begin
            w_state_next = ST_BUF_WAIT_REFILL;   // Someone already asked for it
            w_entry_next.lrq_index_oh = i_lrq_resp.index_oh;
          end else if (i_lrq_resp.full) begin
            w_state_next = ST_BUF_WAIT_FULL;
          end else begin
            w_state_next = ST_BUF_RD_L1D;   // Fresh slot, search again on replay
          end
        end
      end
      ST_BUF_WAIT_REFILL: begin
        if (w_resolve_match || !w_dep_alive) w_state_next = ST_BUF_RD_L1D;
      end
      ST_BUF_WAIT_FULL: begin
        if (!i_lrq_resp.full) w_state_next = ST_BUF_RD_L1D;
      end
      ST_BUF_L1D_UPDATE: begin
        if (i_l1d_wr_accepted) w_state_next = ST_BUF_L1D_UPD_RESP;
      end
      ST_BUF_L1D_UPD_RESP: begin
        // Line may have been replaced since the tag check
        w_state_next = i_l1d_wr_s1_resp_hit ? ST_BUF_WAIT_FINISH : ST_BUF_RD_L1D;
      end
      ST_BUF_WAIT_FINISH: begin
        if (i_finish_accepted) begin
          w_state_next       = ST_BUF_INIT;
          w_entry_next.valid = 1'b0;
        end
      end
      default: begin
        w_state_next = ST_BUF_INIT;
      end
    endcase
  end

  assign o_entry          = r_entry;
  assign o_l1d_rd_req     = r_entry.valid & (r_state == ST_BUF_RD_L1D);
  assign o_l1d_wr_req     = r_entry.valid & (r_state == ST_BUF_L1D_UPDATE);
  assign o_lrq_req        = r_entry.valid & (r_state == ST_BUF_LRQ_REFILL);
  assign o_entry_finish   = r_entry.valid & (r_state == ST_BUF_WAIT_FINISH);
  assign o_ready_to_merge = r_entry.valid &
                            (r_state != ST_BUF_L1D_UPDATE) &
                            (r_state != ST_BUF_L1D_UPD_RESP) &
                            (r_state != ST_BUF_WAIT_FINISH);

  // ------------------------------------------------------------
  // Forward check
  // ------------------------------------------------------------
  assign w_entry_dw = r_entry.paddr[PADDR_W-1:DW_OFS_W];
  assign w_fwd_dw   = i_fwd_paddr[PADDR_W-1:DW_OFS_W];
  assign o_fwd_hit  = r_entry.valid & i_fwd_valid & (w_entry_dw == w_fwd_dw);

endmodule

// ==== vlog.f ====
common/stbuf_pkg.sv
st_buffer/st_buffer_entry.sv
st_buffer/st_buffer.sv
hdl/l1d_array.sv
hdl/refill_queue.sv
hdl/stbuf_subsys.sv
bench/tb_clk_gen.sv
bench/stbuf_tb.sv
